/* hdl/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	typedef logic [31:0] inst_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] shamt_t;

	// Primary opcodes
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_ANDI = 6'b001100;
	localparam opcode_t OP_ORI = 6'b001101;
	localparam opcode_t OP_XORI = 6'b001110;
	localparam opcode_t OP_LUI = 6'b001111;
	localparam opcode_t OP_ADDI = 6'b001000;
	localparam opcode_t OP_ADDIU = 6'b001001;
	localparam opcode_t OP_SLTI = 6'b001010;
	localparam opcode_t OP_SLTIU = 6'b001011;

	// SPECIAL function codes
	localparam funct_t FN_AND = 6'b100100;
	localparam funct_t FN_OR = 6'b100101;
	localparam funct_t FN_XOR = 6'b100110;
	localparam funct_t FN_NOR = 6'b100111;
	localparam funct_t FN_SLL = 6'b000000;
	localparam funct_t FN_SRL = 6'b000010;
	localparam funct_t FN_SRA = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRLV = 6'b000110;
	localparam funct_t FN_SRAV = 6'b000111;
	localparam funct_t FN_ADD = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_SLT = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

endpackage

`default_nettype wire

/* hdl/mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam int NUM_REGS = 32;
	localparam reg_addr_t NOP_REG_ADDR = 5'd0;

	// Operation code handed to EX
	typedef enum logic [7:0] {
		ALU_NOP = 8'b0000_0000,
		ALU_OR = 8'b0010_0101,
		ALU_AND = 8'b0010_0100,
		ALU_XOR = 8'b0010_0110,
		ALU_NOR = 8'b0010_0111,
		ALU_SLL = 8'b0111_1100,
		ALU_SRL = 8'b0000_0010,
		ALU_SRA = 8'b0000_0011,
		ALU_SLT = 8'b0010_1010,
		ALU_SLTU = 8'b0010_1011,
		ALU_ADD = 8'b0010_0000,
		ALU_ADDU = 8'b0010_0001,
		ALU_SUB = 8'b0010_0010,
		ALU_SUBU = 8'b0010_0011,
		ALU_ADDI = 8'b0101_0101,
		ALU_ADDIU = 8'b0101_0110
	} aluop_e;

	// Result group selected in EX
	typedef enum logic [2:0] {
		SEL_NOP = 3'b000,
		SEL_LOGIC = 3'b001,
		SEL_SHIFT = 3'b010,
		SEL_ARITH = 3'b100
	} alusel_e;

endpackage

`default_nettype wire

/* hdl/id_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
	input mips_isa_pkg::inst_t inst_i,
	output mips_ctrl_pkg::aluop_e aluop_o,
	output mips_ctrl_pkg::alusel_e alusel_o,
	output logic we_o,
	output mips_ctrl_pkg::reg_addr_t waddr_o,
	output logic rd1_en_o,
	output logic rd2_en_o,
	output mips_ctrl_pkg::reg_addr_t rd1_addr_o,
	output mips_ctrl_pkg::reg_addr_t rd2_addr_o,
	output mips_ctrl_pkg::word_t imm_o,
	output logic invalid_o
);

	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	opcode_t opcode;
	funct_t funct;
	shamt_t shamt;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;

	word_t imm_zext;
	word_t imm_sext;
	word_t imm_upper;
	word_t imm_shamt;

	logic is_r3; // rs, rt -> rd
	logic is_imm; // rs, imm -> rt
	logic is_shift; // rt, shamt -> rd

	assign opcode = inst_i[31:26];
	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign funct = inst_i[5:0];

	assign imm_zext = {16'h0000, inst_i[15:0]};
	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm_upper = {inst_i[15:0], 16'h0000};
	assign imm_shamt = {27'd0, shamt};

	assign rd1_addr_o = rs;
	assign rd2_addr_o = rt;

	always_comb begin
		aluop_o = ALU_NOP;
		alusel_o = SEL_NOP;
		imm_o = '0;
		is_r3 = 1'b0;
		is_imm = 1'b0;
		is_shift = 1'b0;

		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_OR: begin
						aluop_o = ALU_OR;
						alusel_o = SEL_LOGIC;
						is_r3 = 1'b1;
					end
					FN_AND: begin
						aluop_o = ALU_AND;
						alusel_o = SEL_LOGIC;
						is_r3 = 1'b1;
					end
					FN_XOR: begin
						aluop_o = ALU_XOR;
						alusel_o = SEL_LOGIC;
						is_r3 = 1'b1;
					end
					FN_NOR: begin
						aluop_o = ALU_NOR;
						alusel_o = SEL_LOGIC;
						is_r3 = 1'b1;
					end
					FN_SLLV: begin
						aluop_o = ALU_SLL;
						alusel_o = SEL_SHIFT;
						is_r3 = 1'b1;
					end
					FN_SRLV: begin
						aluop_o = ALU_SRL;
						alusel_o = SEL_SHIFT;
						is_r3 = 1'b1;
					end
					FN_SRAV: begin
						aluop_o = ALU_SRA;
						alusel_o = SEL_SHIFT;
						is_r3 = 1'b1;
					end
					FN_SLT: begin
						aluop_o = ALU_SLT;
						alusel_o = SEL_ARITH;
						is_r3 = 1'b1;
					end
					FN_SLTU: begin
						aluop_o = ALU_SLTU;
						alusel_o = SEL_ARITH;
						is_r3 = 1'b1;
					end
					FN_ADD: begin
						aluop_o = ALU_ADD;
						alusel_o = SEL_ARITH;
						is_r3 = 1'b1;
					end
					FN_ADDU: begin
						aluop_o = ALU_ADDU;
						alusel_o = SEL_ARITH;
						is_r3 = 1'b1;
					end
					FN_SUB: begin
						aluop_o = ALU_SUB;
						alusel_o = SEL_ARITH;
						is_r3 = 1'b1;
					end
					FN_SUBU: begin
						aluop_o = ALU_SUBU;
						alusel_o = SEL_ARITH;
						is_r3 = 1'b1;
					end
					FN_SLL, FN_SRL, FN_SRA: begin
						if (rs == 5'd0) begin // Upper 11 bits must be zero
							alusel_o = SEL_SHIFT;
							imm_o = imm_shamt;
							is_shift = 1'b1;
							case (funct)
								FN_SLL: aluop_o = ALU_SLL;
								FN_SRL: aluop_o = ALU_SRL;
								default: aluop_o = ALU_SRA;
							endcase
						end
					end
					default: begin
					end
				endcase
			end
			OP_ORI: begin
				aluop_o = ALU_OR;
				alusel_o = SEL_LOGIC;
				imm_o = imm_zext;
				is_imm = 1'b1;
			end
			OP_ANDI: begin
				aluop_o = ALU_AND;
				alusel_o = SEL_LOGIC;
				imm_o = imm_zext;
				is_imm = 1'b1;
			end
			OP_XORI: begin
				aluop_o = ALU_XOR;
				alusel_o = SEL_LOGIC;
				imm_o = imm_zext;
				is_imm = 1'b1;
			end
			OP_LUI: begin
				aluop_o = ALU_OR; // rs OR upper half
				alusel_o = SEL_LOGIC;
				imm_o = imm_upper;
				is_imm = 1'b1;
			end
			OP_ADDI: begin
				aluop_o = ALU_ADDI;
				alusel_o = SEL_ARITH;
				imm_o = imm_sext;
				is_imm = 1'b1;
			end
			OP_ADDIU: begin
				aluop_o = ALU_ADDIU;
				alusel_o = SEL_ARITH;
				imm_o = imm_sext;
				is_imm = 1'b1;
			end
			OP_SLTI: begin
				aluop_o = ALU_SLT;
				alusel_o = SEL_ARITH;
				imm_o = imm_sext;
				is_imm = 1'b1;
			end
			OP_SLTIU: begin
				aluop_o = ALU_SLTU;
				alusel_o = SEL_ARITH;
				imm_o = imm_sext; // Sign-extended, compared unsigned
				is_imm = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// Read enables and destination follow the instruction form
	always_comb begin
		we_o = is_r3 | is_imm | is_shift;
		rd1_en_o = is_r3 | is_imm;
		rd2_en_o = is_r3 | is_shift;
		invalid_o = ~(is_r3 | is_imm | is_shift);
		if (is_imm) begin
			waddr_o = rt;
		end else if (is_r3 || is_shift) begin
			waddr_o = rd;
		end else begin
			waddr_o = NOP_REG_ADDR;
		end
	end

endmodule

`default_nettype wire

/* hdl/id_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module id_regfile (
	input logic clk_i,
	input logic rst_n_i,
	input logic we_i,
	input mips_ctrl_pkg::reg_addr_t waddr_i,
	input mips_ctrl_pkg::word_t wdata_i,
	input mips_ctrl_pkg::reg_addr_t raddr1_i,
	input mips_ctrl_pkg::reg_addr_t raddr2_i,
	output mips_ctrl_pkg::word_t rdata1_o,
	output mips_ctrl_pkg::word_t rdata2_o
);

	import mips_ctrl_pkg::*;

	word_t regs [NUM_REGS];

	// r0 reads zero, same-cycle write passes through
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == NOP_REG_ADDR) begin
			return '0;
		end else if (we_i && (waddr_i == addr)) begin
			return wdata_i;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != NOP_REG_ADDR)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

`default_nettype wire

/* hdl/id_operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux (
	input logic rd_en_i,
	input mips_ctrl_pkg::reg_addr_t rd_addr_i,
	input mips_ctrl_pkg::word_t rf_data_i,
	input mips_ctrl_pkg::word_t imm_i,
	input logic ex_we_i,
	input mips_ctrl_pkg::reg_addr_t ex_waddr_i,
	input mips_ctrl_pkg::word_t ex_wdata_i,
	input logic mem_we_i,
	input mips_ctrl_pkg::reg_addr_t mem_waddr_i,
	input mips_ctrl_pkg::word_t mem_wdata_i,
	output mips_ctrl_pkg::word_t operand_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit = ex_we_i && (ex_waddr_i == rd_addr_i);
	assign mem_hit = mem_we_i && (mem_waddr_i == rd_addr_i);

	always_comb begin
		if (rd_en_i && ex_hit) begin
			operand_o = ex_wdata_i; // Youngest result wins
		end else if (rd_en_i && mem_hit) begin
			operand_o = mem_wdata_i;
		end else if (rd_en_i) begin
			operand_o = rf_data_i;
		end else begin
			operand_o = imm_i;
		end
	end

endmodule

`default_nettype wire

/* hdl/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
	input logic clk_i,
	input logic rst_n_i,
	input mips_ctrl_pkg::aluop_e aluop_i,
	input mips_ctrl_pkg::alusel_e alusel_i,
	input mips_ctrl_pkg::word_t reg1_i,
	input mips_ctrl_pkg::word_t reg2_i,
	input mips_ctrl_pkg::reg_addr_t waddr_i,
	input logic we_i,
	input logic invalid_i,
	output mips_ctrl_pkg::aluop_e aluop_o,
	output mips_ctrl_pkg::alusel_e alusel_o,
	output mips_ctrl_pkg::word_t reg1_o,
	output mips_ctrl_pkg::word_t reg2_o,
	output mips_ctrl_pkg::reg_addr_t waddr_o,
	output logic we_o,
	output logic invalid_o
);

	import mips_ctrl_pkg::*;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			aluop_o <= ALU_NOP;
			alusel_o <= SEL_NOP;
			reg1_o <= '0;
			reg2_o <= '0;
			waddr_o <= NOP_REG_ADDR;
			we_o <= 1'b0;
			invalid_o <= 1'b0; // No instruction yet
		end else begin
			aluop_o <= aluop_i;
			alusel_o <= alusel_i;
			reg1_o <= reg1_i;
			reg2_o <= reg2_i;
			waddr_o <= waddr_i;
			we_o <= we_i;
			invalid_o <= invalid_i;
		end
	end

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input logic clk_i,
	input logic rst_n_i,
	input mips_isa_pkg::inst_t inst_i,

	input logic wb_we_i,
	input mips_ctrl_pkg::reg_addr_t wb_addr_i,
	input mips_ctrl_pkg::word_t wb_data_i,

	input logic ex_we_i,
	input mips_ctrl_pkg::reg_addr_t ex_waddr_i,
	input mips_ctrl_pkg::word_t ex_wdata_i,

	input logic mem_we_i,
	input mips_ctrl_pkg::reg_addr_t mem_waddr_i,
	input mips_ctrl_pkg::word_t mem_wdata_i,

	output mips_ctrl_pkg::aluop_e ex_aluop_o,
	output mips_ctrl_pkg::alusel_e ex_alusel_o,
	output mips_ctrl_pkg::word_t ex_reg1_o,
	output mips_ctrl_pkg::word_t ex_reg2_o,
	output mips_ctrl_pkg::reg_addr_t ex_waddr_o,
	output logic ex_we_o,
	output logic inst_invalid_o
);

	import mips_ctrl_pkg::*;

	aluop_e dec_aluop;
	alusel_e dec_alusel;
	logic dec_we;
	reg_addr_t dec_waddr;
	logic rd1_en;
	logic rd2_en;
	reg_addr_t rd1_addr;
	reg_addr_t rd2_addr;
	word_t dec_imm;
	logic dec_invalid;
	word_t rf_data1;
	word_t rf_data2;
	word_t operand1;
	word_t operand2;

	id_decoder u_decoder (
		.inst_i (inst_i),
		.aluop_o (dec_aluop),
		.alusel_o (dec_alusel),
		.we_o (dec_we),
		.waddr_o (dec_waddr),
		.rd1_en_o (rd1_en),
		.rd2_en_o (rd2_en),
		.rd1_addr_o (rd1_addr),
		.rd2_addr_o (rd2_addr),
		.imm_o (dec_imm),
		.invalid_o (dec_invalid)
	);

	id_regfile u_regfile (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.we_i (wb_we_i),
		.waddr_i (wb_addr_i),
		.wdata_i (wb_data_i),
		.raddr1_i (rd1_addr),
		.raddr2_i (rd2_addr),
		.rdata1_o (rf_data1),
		.rdata2_o (rf_data2)
	);

	id_operand_mux u_operand1 (
		.rd_en_i (rd1_en),
		.rd_addr_i (rd1_addr),
		.rf_data_i (rf_data1),
		.imm_i (dec_imm),
		.ex_we_i (ex_we_i),
		.ex_waddr_i (ex_waddr_i),
		.ex_wdata_i (ex_wdata_i),
		.mem_we_i (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o (operand1)
	);

	id_operand_mux u_operand2 (
		.rd_en_i (rd2_en),
		.rd_addr_i (rd2_addr),
		.rf_data_i (rf_data2),
		.imm_i (dec_imm),
		.ex_we_i (ex_we_i),
		.ex_waddr_i (ex_waddr_i),
		.ex_wdata_i (ex_wdata_i),
		.mem_we_i (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o (operand2)
	);

	id_ex_reg u_id_ex (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.aluop_i (dec_aluop),
		.alusel_i (dec_alusel),
		.reg1_i (operand1),
		.reg2_i (operand2),
		.waddr_i (dec_waddr),
		.we_i (dec_we),
		.invalid_i (dec_invalid),
		.aluop_o (ex_aluop_o),
		.alusel_o (ex_alusel_o),
		.reg1_o (ex_reg1_o),
		.reg2_o (ex_reg2_o),
		.waddr_o (ex_waddr_o),
		.we_o (ex_we_o),
		.invalid_o (inst_invalid_o)
	);

endmodule

`default_nettype wire

/* testbench/id_stage_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_properties (
	input logic clk_i,
	input logic rst_n_i,
	input mips_ctrl_pkg::aluop_e ex_aluop_i,
	input mips_ctrl_pkg::alusel_e ex_alusel_i,
	input mips_ctrl_pkg::word_t ex_reg1_i,
	input mips_ctrl_pkg::word_t ex_reg2_i,
	input mips_ctrl_pkg::reg_addr_t ex_waddr_i,
	input logic ex_we_i,
	input logic inst_invalid_i
);

	import mips_ctrl_pkg::*;

	// An edge seen in reset leaves the ID/EX register inactive
	reset_inactive: assert property (@(posedge clk_i)
		!rst_n_i |=> (ex_aluop_i == ALU_NOP) && (ex_alusel_i == SEL_NOP) &&
			(ex_reg1_i == '0) && (ex_reg2_i == '0) && (ex_waddr_i == NOP_REG_ADDR) &&
			!ex_we_i && !inst_invalid_i)
		else $error("ID/EX outputs not inactive in reset");

	// Unknown encodings carry no write, no destination and zero operands
	invalid_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		inst_invalid_i |-> !ex_we_i && (ex_waddr_i == NOP_REG_ADDR) &&
			(ex_reg1_i == '0) && (ex_reg2_i == '0))
		else $error("Invalid instruction left the NOP state");

	nop_pairing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(ex_alusel_i == SEL_NOP) == (ex_aluop_i == ALU_NOP))
		else $error("alusel and aluop disagree on NOP");

endmodule

bind id_stage id_stage_properties u_properties (
	.clk_i (clk_i),
	.rst_n_i (rst_n_i),
	.ex_aluop_i (ex_aluop_o),
	.ex_alusel_i (ex_alusel_o),
	.ex_reg1_i (ex_reg1_o),
	.ex_reg2_i (ex_reg2_o),
	.ex_waddr_i (ex_waddr_o),
	.ex_we_i (ex_we_o),
	.inst_invalid_i (inst_invalid_o)
);

`default_nettype wire

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	localparam logic [31:0] SEED = 32'hd9da_6a65;
	localparam int RESET_TIMEOUT = 16;

	logic clk_i;
	logic rst_n_i;
	inst_t inst_i;
	logic wb_we_i;
	reg_addr_t wb_addr_i;
	word_t wb_data_i;
	logic ex_we_i;
	reg_addr_t ex_waddr_i;
	word_t ex_wdata_i;
	logic mem_we_i;
	reg_addr_t mem_waddr_i;
	word_t mem_wdata_i;
	aluop_e ex_aluop_o;
	alusel_e ex_alusel_o;
	word_t ex_reg1_o;
	word_t ex_reg2_o;
	reg_addr_t ex_waddr_o;
	logic ex_we_o;
	logic inst_invalid_o;

	word_t mirror [NUM_REGS];
	int errors;
	int checks;
	logic timed_out;

	// Forwarding state picked up by the next table entries
	logic f_ex_we;
	reg_addr_t f_ex_addr;
	word_t f_ex_data;
	logic f_mem_we;
	reg_addr_t f_mem_addr;
	word_t f_mem_data;

	inst_t t_inst [$];
	logic [75:0] t_fwd [$]; // {ex we, addr, data, mem we, addr, data}
	logic [7:0] t_aluop [$];
	logic [2:0] t_alusel [$];
	word_t t_op1 [$];
	word_t t_op2 [$];
	reg_addr_t t_waddr [$];
	logic t_we [$];
	logic t_inv [$];

	id_stage u_id_stage (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.inst_i (inst_i),
		.wb_we_i (wb_we_i),
		.wb_addr_i (wb_addr_i),
		.wb_data_i (wb_data_i),
		.ex_we_i (ex_we_i),
		.ex_waddr_i (ex_waddr_i),
		.ex_wdata_i (ex_wdata_i),
		.mem_we_i (mem_we_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_wdata_i (mem_wdata_i),
		.ex_aluop_o (ex_aluop_o),
		.ex_alusel_o (ex_alusel_o),
		.ex_reg1_o (ex_reg1_o),
		.ex_reg2_o (ex_reg2_o),
		.ex_waddr_o (ex_waddr_o),
		.ex_we_o (ex_we_o),
		.inst_invalid_o (inst_invalid_o)
	);

	always #2 clk_i = ~clk_i;

	initial begin
		rst_n_i = 1'b0;
		repeat (4) @(posedge clk_i);
		rst_n_i <= 1'b1;
	end

	function automatic inst_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input shamt_t sa, input funct_t fn);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic inst_t enc_i(input opcode_t op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic check_value(input string sig, input string ctx,
		input logic [31:0] actual, input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s (%s): got 0x%h, expected 0x%h", sig, ctx, actual, expected);
		end
	endtask

	task automatic set_fwd(input logic ex_we, input reg_addr_t ex_addr, input word_t ex_data,
		input logic mem_we, input reg_addr_t mem_addr, input word_t mem_data);
		f_ex_we = ex_we;
		f_ex_addr = ex_addr;
		f_ex_data = ex_data;
		f_mem_we = mem_we;
		f_mem_addr = mem_addr;
		f_mem_data = mem_data;
	endtask

	task automatic push_entry(input inst_t inst, input logic [7:0] aluop,
		input logic [2:0] alusel, input word_t op1, input word_t op2,
		input reg_addr_t waddr, input logic we, input logic inv);
		t_inst.push_back(inst);
		t_fwd.push_back({f_ex_we, f_ex_addr, f_ex_data, f_mem_we, f_mem_addr, f_mem_data});
		t_aluop.push_back(aluop);
		t_alusel.push_back(alusel);
		t_op1.push_back(op1);
		t_op2.push_back(op2);
		t_waddr.push_back(waddr);
		t_we.push_back(we);
		t_inv.push_back(inv);
	endtask

	// Three-register form without a forwarding hit
	task automatic push_rr(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [7:0] aluop, input logic [2:0] alusel);
		push_entry(enc_r(rs, rt, rd, 5'd0, fn), aluop, alusel, mirror[rs], mirror[rt],
			rd, 1'b1, 1'b0);
	endtask

	task automatic push_imm(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
		input logic [15:0] imm, input logic [7:0] aluop, input logic [2:0] alusel,
		input word_t imm_exp);
		push_entry(enc_i(op, rs, rt, imm), aluop, alusel, mirror[rs], imm_exp, rt, 1'b1, 1'b0);
	endtask

	task automatic push_shift(input funct_t fn, input reg_addr_t rt, input reg_addr_t rd,
		input shamt_t sa, input logic [7:0] aluop, input word_t sa_exp);
		push_entry(enc_r(5'd0, rt, rd, sa, fn), aluop, SEL_SHIFT, sa_exp, mirror[rt],
			rd, 1'b1, 1'b0);
	endtask

	task automatic push_bad(input inst_t inst);
		push_entry(inst, ALU_NOP, SEL_NOP, '0, '0, NOP_REG_ADDR, 1'b0, 1'b1);
	endtask

	task automatic build_table();
		word_t ex_d;
		word_t mem_d;
		ex_d = $urandom();
		mem_d = $urandom();
		set_fwd(1'b0, 5'd0, '0, 1'b0, 5'd0, '0);
		push_rr(FN_OR, 5'd1, 5'd2, 5'd3, ALU_OR, SEL_LOGIC);
		push_rr(FN_AND, 5'd4, 5'd5, 5'd6, ALU_AND, SEL_LOGIC);
		push_rr(FN_XOR, 5'd7, 5'd8, 5'd9, ALU_XOR, SEL_LOGIC);
		push_rr(FN_NOR, 5'd10, 5'd11, 5'd12, ALU_NOR, SEL_LOGIC);
		push_rr(FN_SLLV, 5'd13, 5'd14, 5'd15, ALU_SLL, SEL_SHIFT);
		push_rr(FN_SRLV, 5'd16, 5'd17, 5'd18, ALU_SRL, SEL_SHIFT);
		push_rr(FN_SRAV, 5'd19, 5'd20, 5'd21, ALU_SRA, SEL_SHIFT);
		push_rr(FN_ADD, 5'd22, 5'd23, 5'd24, ALU_ADD, SEL_ARITH);
		push_rr(FN_ADDU, 5'd0, 5'd31, 5'd17, ALU_ADDU, SEL_ARITH); // r0 reads zero
		push_rr(FN_SUB, 5'd25, 5'd26, 5'd27, ALU_SUB, SEL_ARITH);
		push_rr(FN_SUBU, 5'd28, 5'd29, 5'd30, ALU_SUBU, SEL_ARITH);
		push_rr(FN_SLT, 5'd31, 5'd1, 5'd2, ALU_SLT, SEL_ARITH);
		push_rr(FN_SLTU, 5'd3, 5'd4, 5'd5, ALU_SLTU, SEL_ARITH);
		push_imm(OP_ORI, 5'd5, 5'd20, 16'h8a5c, ALU_OR, SEL_LOGIC, 32'h0000_8a5c);
		push_imm(OP_ANDI, 5'd6, 5'd21, 16'hf00f, ALU_AND, SEL_LOGIC, 32'h0000_f00f);
		push_imm(OP_XORI, 5'd7, 5'd22, 16'h1234, ALU_XOR, SEL_LOGIC, 32'h0000_1234);
		push_imm(OP_LUI, 5'd0, 5'd23, 16'hbeef, ALU_OR, SEL_LOGIC, 32'hbeef_0000);
		push_imm(OP_ADDI, 5'd8, 5'd24, 16'hff80, ALU_ADDI, SEL_ARITH, 32'hffff_ff80);
		push_imm(OP_ADDIU, 5'd9, 5'd25, 16'h7fff, ALU_ADDIU, SEL_ARITH, 32'h0000_7fff);
		push_imm(OP_SLTI, 5'd10, 5'd26, 16'h8000, ALU_SLT, SEL_ARITH, 32'hffff_8000);
		push_imm(OP_SLTIU, 5'd11, 5'd27, 16'hfffe, ALU_SLTU, SEL_ARITH, 32'hffff_fffe);
		push_shift(FN_SLL, 5'd9, 5'd30, 5'd5, ALU_SLL, 32'h0000_0005);
		push_shift(FN_SRL, 5'd12, 5'd29, 5'd31, ALU_SRL, 32'h0000_001f);
		push_shift(FN_SRA, 5'd13, 5'd28, 5'd16, ALU_SRA, 32'h0000_0010);
		push_shift(FN_SLL, 5'd0, 5'd0, 5'd0, ALU_SLL, 32'h0000_0000); // All-zero word
		// EX beats MEM when both hit rs
		set_fwd(1'b1, 5'd1, ex_d, 1'b1, 5'd1, mem_d);
		push_entry(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), ALU_ADD, SEL_ARITH,
			ex_d, mirror[2], 5'd3, 1'b1, 1'b0);
		set_fwd(1'b1, 5'd7, ex_d, 1'b1, 5'd1, mem_d);
		push_entry(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), ALU_ADD, SEL_ARITH,
			mem_d, mirror[2], 5'd3, 1'b1, 1'b0);
		set_fwd(1'b0, 5'd1, ex_d, 1'b1, 5'd2, mem_d); // EX hit without enable
		push_entry(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FN_OR), ALU_OR, SEL_LOGIC,
			mirror[1], mem_d, 5'd3, 1'b1, 1'b0);
		set_fwd(1'b1, 5'd2, ex_d, 1'b0, 5'd1, mem_d);
		push_entry(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FN_OR), ALU_OR, SEL_LOGIC,
			mirror[1], ex_d, 5'd3, 1'b1, 1'b0);
		set_fwd(1'b1, 5'd4, ex_d, 1'b1, 5'd5, mem_d);
		push_rr(FN_XOR, 5'd1, 5'd2, 5'd3, ALU_XOR, SEL_LOGIC);
		set_fwd(1'b1, 5'd6, ex_d, 1'b1, 5'd6, mem_d); // rt is only the destination
		push_imm(OP_ORI, 5'd5, 5'd6, 16'h00ff, ALU_OR, SEL_LOGIC, 32'h0000_00ff);
		set_fwd(1'b1, 5'd1, ex_d, 1'b1, 5'd2, mem_d);
		push_bad(enc_r(5'd1, 5'd2, 5'd0, 5'd0, 6'b011000)); // MULT
		set_fwd(1'b0, 5'd0, '0, 1'b0, 5'd0, '0);
		push_bad(enc_i(6'b100011, 5'd1, 5'd2, 16'h0010)); // LW
		push_bad(enc_r(5'd3, 5'd4, 5'd5, 5'd2, FN_SLL));
		push_bad(enc_r(5'd0, 5'd0, 5'd8, 5'd0, 6'b010000)); // MFHI
	endtask

	task automatic check_idle(input string ctx);
		check_value("ex_aluop_o", ctx, ex_aluop_o, ALU_NOP);
		check_value("ex_alusel_o", ctx, ex_alusel_o, SEL_NOP);
		check_value("ex_reg1_o", ctx, ex_reg1_o, '0);
		check_value("ex_reg2_o", ctx, ex_reg2_o, '0);
		check_value("ex_waddr_o", ctx, ex_waddr_o, '0);
		check_value("ex_we_o", ctx, ex_we_o, 1'b0);
		check_value("inst_invalid_o", ctx, inst_invalid_o, 1'b0);
	endtask

	task automatic check_entry(input int k);
		string ctx;
		ctx = $sformatf("entry %0d", k);
		check_value("ex_aluop_o", ctx, ex_aluop_o, t_aluop[k]);
		check_value("ex_alusel_o", ctx, ex_alusel_o, t_alusel[k]);
		check_value("ex_reg1_o", ctx, ex_reg1_o, t_op1[k]);
		check_value("ex_reg2_o", ctx, ex_reg2_o, t_op2[k]);
		check_value("ex_waddr_o", ctx, ex_waddr_o, t_waddr[k]);
		check_value("ex_we_o", ctx, ex_we_o, t_we[k]);
		check_value("inst_invalid_o", ctx, inst_invalid_o, t_inv[k]);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (!rst_n_i && cycles < RESET_TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (!rst_n_i) begin
			$display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic preload_registers();
		word_t val;
		mirror[0] = '0;
		for (int r = 1; r < NUM_REGS; r++) begin
			val = $urandom();
			mirror[r] = val;
			@(posedge clk_i);
			wb_we_i <= 1'b1;
			wb_addr_i <= reg_addr_t'(r);
			wb_data_i <= val;
		end
		@(posedge clk_i);
		wb_addr_i <= NOP_REG_ADDR; // Must be dropped
		wb_data_i <= $urandom();
		@(posedge clk_i);
		wb_we_i <= 1'b0;
	endtask

	// One entry per cycle, each result checked one edge later
	task automatic run_table();
		int n;
		n = t_inst.size();
		for (int i = 0; i <= n; i++) begin
			@(posedge clk_i);
			if (i < n) begin
				inst_i <= t_inst[i];
				{ex_we_i, ex_waddr_i, ex_wdata_i, mem_we_i, mem_waddr_i, mem_wdata_i} <= t_fwd[i];
			end else begin
				inst_i <= '0;
				{ex_we_i, ex_waddr_i, ex_wdata_i, mem_we_i, mem_waddr_i, mem_wdata_i} <= '0;
			end
			@(negedge clk_i);
			if (i > 0) begin
				check_entry(i - 1);
			end
		end
	endtask

	task automatic finish_run();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	initial begin
		clk_i = 1'b0;
		inst_i = '0;
		wb_we_i = 1'b0;
		wb_addr_i = '0;
		wb_data_i = '0;
		ex_we_i = 1'b0;
		ex_waddr_i = '0;
		ex_wdata_i = '0;
		mem_we_i = 1'b0;
		mem_waddr_i = '0;
		mem_wdata_i = '0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		void'($urandom(SEED));
		@(negedge clk_i);
		check_idle("in reset");
		wait_reset_release();
		if (!timed_out) begin
			check_idle("after reset");
			preload_registers();
			build_table();
			run_table();
		end
		finish_run();
	end

endmodule

`default_nettype wire

/* flist.f */
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/id_decoder.sv
hdl/id_regfile.sv
hdl/id_operand_mux.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
testbench/id_stage_properties.sv
testbench/tb_id_stage.sv
